//--- design/cordic_pkg.sv
// shared widths, APB register map and arctangent table for the CORDIC engine
// imported by the RTL and by the testbench
`default_nettype none

package cordic_pkg;

  // datapath defaults, overridden from the top level
  localparam int data_width_default = 16;
  localparam int angle_width_default = 16;
  localparam int stages_default = 13;

  // depth of the arctangent table, upper bound for stages
  localparam int max_stages = 24;

  // APB address bus width
  localparam int apb_addr_width = 8;

  // register byte offsets
  localparam logic [apb_addr_width-1:0] ctrl_addr = 8'h00;
  localparam logic [apb_addr_width-1:0] x_start_addr = 8'h04;
  localparam logic [apb_addr_width-1:0] y_start_addr = 8'h08;
  localparam logic [apb_addr_width-1:0] angle_addr = 8'h0C;
  // read-only group
  localparam logic [apb_addr_width-1:0] status_addr = 8'h10;
  localparam logic [apb_addr_width-1:0] cosine_addr = 8'h14;
  localparam logic [apb_addr_width-1:0] sine_addr = 8'h18;
  localparam logic [apb_addr_width-1:0] count_addr = 8'h1C;

  // status bit positions
  localparam int status_busy_bit = 0;
  localparam int status_done_bit = 1;

  // atan(2^-i) as a fraction of a full turn, times 2^32, rounded
  // entry 0 is 45 degrees, i.e. one eighth of a turn
  // users take the top angle_width bits and round on the next one down
  localparam logic [31:0] atan_table [0:max_stages-1] = '{
    32'h2000_0000, 32'h12E4_051E, 32'h09FB_385B, 32'h0511_11D4,
    32'h028B_0D43, 32'h0145_D7E1, 32'h00A2_F61E, 32'h0051_7C55,
    32'h0028_BE53, 32'h0014_5F2F, 32'h000A_2F98, 32'h0005_17CC,
    32'h0002_8BE6, 32'h0001_45F3, 32'h0000_A2FA, 32'h0000_517D,
    32'h0000_28BE, 32'h0000_145F, 32'h0000_0A30, 32'h0000_0518,
    32'h0000_028C, 32'h0000_0146, 32'h0000_00A3, 32'h0000_0051
  };

endpackage

`default_nettype wire

//--- design/cordic_rotator.sv
// fully pipelined CORDIC rotator in rotation mode, one vector accepted per clock
// quadrant pre-rotation stage first, then one add/shift stage per iteration
`timescale 1ns/100ps
`default_nettype none

module cordic_rotator
  import cordic_pkg::*;
#(
  parameter int data_width = data_width_default,
  parameter int angle_width = angle_width_default,
  parameter int stages = stages_default
) (
  input  wire logic                          clock,
  input  wire logic                          rst_n,
  input  wire logic                          in_valid,
  input  wire logic signed [data_width-1:0]  x_in,
  input  wire logic signed [data_width-1:0]  y_in,
  input  wire logic signed [angle_width-1:0] angle_in,
  output logic                               out_valid,
  output logic signed [data_width-1:0]       cos_out,
  output logic signed [data_width-1:0]       sin_out
);

  // one guard bit on x and y for the CORDIC gain
  logic signed [data_width:0] x_q [0:stages];
  logic signed [data_width:0] y_q [0:stages];
  // residual angle per stage
  logic signed [angle_width-1:0] z_q [0:stages];
  // valid bit travelling with each stage
  logic [stages:0] valid_q;

  // top two angle bits select the quadrant
  logic [1:0] quadrant;
  logic signed [data_width:0] x_ext;
  logic signed [data_width:0] y_ext;

  // per-iteration angle step, top angle_width bits of the table entry
  // rounded on the first dropped bit
  function automatic logic signed [angle_width-1:0] atan_step(input int idx);
    logic [31:0] sum;
    sum = atan_table[idx] + (32'd1 << (31 - angle_width));
    return sum[31 -: angle_width];
  endfunction

  assign quadrant = angle_in[angle_width-1 -: 2];

  // sign extend so that negating the most negative input cannot overflow
  assign x_ext = {x_in[data_width-1], x_in};
  assign y_ext = {y_in[data_width-1], y_in};

  // datapath registers, loaded every clock
  always_ff @(posedge clock)
  begin
    case (quadrant)
      2'b01:
      begin
        // 90 to 180 degrees
        // turn the vector by +90 first, residual loses a quarter turn
        x_q[0] <= -y_ext;
        y_q[0] <= x_ext;
        z_q[0] <= {2'b00, angle_in[angle_width-3:0]};
      end
      2'b10:
      begin
        // -180 to -90 degrees
        // turn by -90 first, residual gains a quarter turn
        x_q[0] <= y_ext;
        y_q[0] <= -x_ext;
        z_q[0] <= {2'b11, angle_in[angle_width-3:0]};
      end
      default:
      begin
        // already within +-90 degrees
        x_q[0] <= x_ext;
        y_q[0] <= y_ext;
        z_q[0] <= angle_in;
      end
    endcase

    // micro-rotations, stage i shifts by i
    for (int i = 0; i < stages; i++)
    begin
      if (z_q[i][angle_width-1])
      begin
        // residual negative, rotate clockwise
        x_q[i+1] <= x_q[i] + (y_q[i] >>> i);
        y_q[i+1] <= y_q[i] - (x_q[i] >>> i);
        z_q[i+1] <= z_q[i] + atan_step(i);
      end
      else
      begin
        // residual zero or positive, rotate counter-clockwise
        x_q[i+1] <= x_q[i] - (y_q[i] >>> i);
        y_q[i+1] <= y_q[i] + (x_q[i] >>> i);
        z_q[i+1] <= z_q[i] - atan_step(i);
      end
    end
  end

  // valid chain, the only state that needs a reset
  always_ff @(posedge clock or negedge rst_n)
  begin
    if (!rst_n)
    begin
      valid_q <= '0;
    end
    else
    begin
      valid_q <= {valid_q[stages-1:0], in_valid};
    end
  end

  assign out_valid = valid_q[stages];

  // drop the guard bit
  // x ends up as the cosine term, y as the sine term
  assign cos_out = x_q[stages][data_width-1:0];
  assign sin_out = y_q[stages][data_width-1:0];

endmodule

`default_nettype wire

//--- design/cordic_regs.sv
// APB3 register block for the CORDIC engine, holds operands and results
// launches one rotation per start write and collects results from the rotator
`timescale 1ns/100ps
`default_nettype none

module cordic_regs
  import cordic_pkg::*;
#(
  parameter int data_width = data_width_default,
  parameter int angle_width = angle_width_default
) (
  input  wire logic                          clock,
  input  wire logic                          rst_n,
  // APB slave
  input  wire logic                          psel,
  input  wire logic                          penable,
  input  wire logic                          pwrite,
  input  wire logic [apb_addr_width-1:0]     paddr,
  input  wire logic [31:0]                   pwdata,
  output logic [31:0]                        prdata,
  output logic                               pready,
  output logic                               pslverr,
  // to the rotator
  output logic                               in_valid,
  output logic signed [data_width-1:0]       x_in,
  output logic signed [data_width-1:0]       y_in,
  output logic signed [angle_width-1:0]      angle_in,
  // from the rotator
  input  wire logic                          out_valid,
  input  wire logic signed [data_width-1:0]  cos_out,
  input  wire logic signed [data_width-1:0]  sin_out
);

  logic access;
  logic wr_en;
  logic rd_en;
  logic start;
  // address decode
  logic addr_hit;
  logic addr_ro;

  logic signed [data_width-1:0] x_start_q;
  logic signed [data_width-1:0] y_start_q;
  logic signed [angle_width-1:0] angle_q;
  logic signed [data_width-1:0] cos_q;
  logic signed [data_width-1:0] sin_q;
  logic [31:0] count_q;
  logic done_q;
  // rotations between launch and capture
  logic [7:0] inflight_q;
  logic busy;

  // access phase of an APB transfer, no wait states
  assign access = psel && penable;
  assign wr_en = access && pwrite;
  assign rd_en = access && !pwrite;
  assign start = wr_en && (paddr == ctrl_addr) && pwdata[0];

  always_comb
  begin
    addr_hit = 1'b1;
    addr_ro = 1'b0;
    case (paddr)
      ctrl_addr, x_start_addr, y_start_addr, angle_addr: ;
      status_addr, cosine_addr, sine_addr, count_addr: addr_ro = 1'b1;
      default: addr_hit = 1'b0;
    endcase
  end

  assign pready = 1'b1;
  // unmapped offset, or a write into the read-only group
  assign pslverr = access && (!addr_hit || (pwrite && addr_ro));

  // operand registers, low bits of the write data
  always_ff @(posedge clock or negedge rst_n)
  begin
    if (!rst_n)
    begin
      x_start_q <= '0;
      y_start_q <= '0;
      angle_q <= '0;
    end
    else if (wr_en)
    begin
      case (paddr)
        x_start_addr: x_start_q <= pwdata[data_width-1:0];
        y_start_addr: y_start_q <= pwdata[data_width-1:0];
        angle_addr: angle_q <= pwdata[angle_width-1:0];
        default: ;
      endcase
    end
  end

  // one-cycle launch pulse after the start write completes
  always_ff @(posedge clock or negedge rst_n)
  begin
    if (!rst_n)
    begin
      in_valid <= 1'b0;
    end
    else
    begin
      in_valid <= start;
    end
  end

  // operands go straight out, sampled by the rotator on the pulse
  assign x_in = x_start_q;
  assign y_in = y_start_q;
  assign angle_in = angle_q;

  // in-flight tracking, launch and capture on the same edge cancel
  always_ff @(posedge clock or negedge rst_n)
  begin
    if (!rst_n)
    begin
      inflight_q <= '0;
    end
    else
    begin
      case ({in_valid, out_valid})
        2'b10: inflight_q <= inflight_q + 8'd1;
        2'b01: inflight_q <= inflight_q - 8'd1;
        default: ;
      endcase
    end
  end

  assign busy = (inflight_q != 8'd0);

  // result capture, newest result wins
  always_ff @(posedge clock or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cos_q <= '0;
      sin_q <= '0;
      count_q <= '0;
    end
    else if (out_valid)
    begin
      cos_q <= cos_out;
      sin_q <= sin_out;
      count_q <= count_q + 32'd1;
    end
  end

  // sticky done, a new start takes priority over a completing rotation
  always_ff @(posedge clock or negedge rst_n)
  begin
    if (!rst_n)
    begin
      done_q <= 1'b0;
    end
    else if (start)
    begin
      done_q <= 1'b0;
    end
    else if (out_valid)
    begin
      done_q <= 1'b1;
    end
  end

  // read mux, signed fields sign extended to the bus width
  always_comb
  begin
    prdata = '0;
    if (rd_en)
    begin
      case (paddr)
        x_start_addr: prdata = 32'(x_start_q);
        y_start_addr: prdata = 32'(y_start_q);
        angle_addr: prdata = 32'(angle_q);
        status_addr:
        begin
          prdata[status_busy_bit] = busy;
          prdata[status_done_bit] = done_q;
        end
        cosine_addr: prdata = 32'(cos_q);
        sine_addr: prdata = 32'(sin_q);
        count_addr: prdata = count_q;
        // ctrl reads as zero
        default: prdata = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- design/cordic_top.sv
// top level of the memory-mapped CORDIC sine/cosine engine
// APB3 register block driving the pipelined rotator
`timescale 1ns/100ps
`default_nettype none

module cordic_top
  import cordic_pkg::*;
#(
  parameter int data_width = data_width_default,
  parameter int angle_width = angle_width_default,
  parameter int stages = stages_default
) (
  input  wire logic                      clock,
  input  wire logic                      rst_n,
  input  wire logic                      psel,
  input  wire logic                      penable,
  input  wire logic                      pwrite,
  input  wire logic [apb_addr_width-1:0] paddr,
  input  wire logic [31:0]               pwdata,
  output logic [31:0]                    prdata,
  output logic                           pready,
  output logic                           pslverr
);

  // launch side
  logic in_valid;
  logic signed [data_width-1:0] x_in;
  logic signed [data_width-1:0] y_in;
  logic signed [angle_width-1:0] angle_in;
  // result side
  logic out_valid;
  logic signed [data_width-1:0] cos_out;
  logic signed [data_width-1:0] sin_out;

  cordic_regs #(
    .data_width  (data_width),
    .angle_width (angle_width)
  ) u_regs (
    .clock     (clock),
    .rst_n     (rst_n),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .in_valid  (in_valid),
    .x_in      (x_in),
    .y_in      (y_in),
    .angle_in  (angle_in),
    .out_valid (out_valid),
    .cos_out   (cos_out),
    .sin_out   (sin_out)
  );

  // result lands stages+1 cycles after the launch pulse
  cordic_rotator #(
    .data_width  (data_width),
    .angle_width (angle_width),
    .stages      (stages)
  ) u_rotator (
    .clock     (clock),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .x_in      (x_in),
    .y_in      (y_in),
    .angle_in  (angle_in),
    .out_valid (out_valid),
    .cos_out   (cos_out),
    .sin_out   (sin_out)
  );

endmodule

`default_nettype wire

//--- dv/cordic_tb.sv
// self-checking testbench for the CORDIC engine, drives the APB port of cordic_top
// compares results against a bit-exact rotation model, stops at the first mismatch
`timescale 1ns/100ps
`default_nettype none

module cordic_tb
  import cordic_pkg::*;
;

  localparam int data_width = data_width_default;
  localparam int angle_width = angle_width_default;
  localparam int stages = stages_default;
  // status reads allowed before a wait gives up
  localparam int poll_limit = 50;

  logic clock;
  logic rst_n;
  logic psel;
  logic penable;
  logic pwrite;
  logic [apb_addr_width-1:0] paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic pready;
  logic pslverr;

  // completed rotations so far
  logic [31:0] expected_count;
  logic [31:0] lcg_state;

  cordic_top UUT (
    .clock   (clock),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  // 4 ns period
  always #2 clock = ~clock;

  task automatic abort_run();
    $display("TEST FAIL");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_data(input string name, input logic signed [data_width-1:0] exp,
                            input logic signed [data_width-1:0] got);
    if (got !== exp)
    begin
      $display("[ERROR] %s expected 0x%h got 0x%h", name, exp, got);
      abort_run();
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (got !== exp)
    begin
      $display("[ERROR] %s expected 0x%h got 0x%h", name, exp, got);
      abort_run();
    end
  endtask

  // numerical recipes constants
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // expected {cosine, sine}, quadrant fold then one micro-rotation per stage
  function automatic logic [2*data_width-1:0] cordic_model(
    input logic signed [data_width-1:0] x_start,
    input logic signed [data_width-1:0] y_start,
    input logic [angle_width-1:0] angle
  );
    logic signed [data_width:0] x;
    logic signed [data_width:0] y;
    logic signed [data_width:0] x_next;
    logic signed [angle_width-1:0] z;
    logic [31:0] rounded;
    // one guard bit above the data width
    x = {x_start[data_width-1], x_start};
    y = {y_start[data_width-1], y_start};
    z = angle;
    case (angle[angle_width-1 -: 2])
      2'b01:
      begin
        // +90 turn, quarter taken off the angle
        x_next = -y;
        y = x;
        x = x_next;
        z = {2'b00, angle[angle_width-3:0]};
      end
      2'b10:
      begin
        // -90 turn, quarter added back
        x_next = y;
        y = -x;
        x = x_next;
        z = {2'b11, angle[angle_width-3:0]};
      end
      default: ;
    endcase
    for (int i = 0; i < stages; i++)
    begin
      // table entry cut to the angle width, rounded on the first dropped bit
      rounded = atan_table[i] + (32'd1 << (31 - angle_width));
      if (z[angle_width-1])
      begin
        x_next = x + (y >>> i);
        y = y - (x >>> i);
        z = z + rounded[31 -: angle_width];
      end
      else
      begin
        x_next = x - (y >>> i);
        y = y + (x >>> i);
        z = z - rounded[31 -: angle_width];
      end
      x = x_next;
    end
    return {x[data_width-1:0], y[data_width-1:0]};
  endfunction

  // setup on one falling edge, access on the next, completes on the rising edge
  task automatic apb_write(input logic [apb_addr_width-1:0] addr, input logic [31:0] data,
                           input logic exp_err);
    @(negedge clock);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = 1'b1;
    paddr = addr;
    pwdata = data;
    @(negedge clock);
    penable = 1'b1;
    // mid low phase, outputs settled
    #1;
    check_word("pready", 32'h1, {31'b0, pready});
    check_word("pslverr", {31'b0, exp_err}, {31'b0, pslverr});
    @(posedge clock);
    @(negedge clock);
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_read(input logic [apb_addr_width-1:0] addr, input logic exp_err,
                          output logic [31:0] data);
    @(negedge clock);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = addr;
    @(negedge clock);
    penable = 1'b1;
    #1;
    data = prdata;
    check_word("pready", 32'h1, {31'b0, pready});
    check_word("pslverr", {31'b0, exp_err}, {31'b0, pslverr});
    @(posedge clock);
    @(negedge clock);
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic read_check(input string name, input logic [apb_addr_width-1:0] addr,
                            input logic [31:0] exp);
    logic [31:0] rd;
    apb_read(addr, 1'b0, rd);
    check_word(name, exp, rd);
  endtask

  // single rotation in flight, so busy stays up until done appears
  task automatic wait_done();
    logic [31:0] st;
    int polls;
    polls = 0;
    apb_read(status_addr, 1'b0, st);
    while (!st[status_done_bit])
    begin
      check_word("status", 32'h1, st);
      polls++;
      if (polls > poll_limit)
      begin
        $display("timed out waiting for done");
        abort_run();
      end
      apb_read(status_addr, 1'b0, st);
    end
  endtask

  task automatic wait_idle();
    logic [31:0] st;
    int polls;
    polls = 0;
    apb_read(status_addr, 1'b0, st);
    while (st[status_busy_bit])
    begin
      polls++;
      if (polls > poll_limit)
      begin
        $display("timed out waiting for busy to clear");
        abort_run();
      end
      apb_read(status_addr, 1'b0, st);
    end
  endtask

  task automatic check_results(input logic [2*data_width-1:0] exp);
    logic signed [data_width-1:0] exp_cos;
    logic signed [data_width-1:0] exp_sin;
    logic [31:0] rd;
    exp_cos = exp[2*data_width-1:data_width];
    exp_sin = exp[data_width-1:0];
    apb_read(cosine_addr, 1'b0, rd);
    check_data("cosine", exp_cos, rd[data_width-1:0]);
    // bits above the result repeat its sign
    check_word("cosine", {{(32-data_width){exp_cos[data_width-1]}}, exp_cos}, rd);
    apb_read(sine_addr, 1'b0, rd);
    check_data("sine", exp_sin, rd[data_width-1:0]);
    check_word("sine", {{(32-data_width){exp_sin[data_width-1]}}, exp_sin}, rd);
  endtask

  // angle write plus start strobe, no polling
  task automatic launch(input logic [angle_width-1:0] angle);
    apb_write(angle_addr, 32'(angle), 1'b0);
    apb_write(ctrl_addr, 32'h1, 1'b0);
    expected_count = expected_count + 32'd1;
  endtask

  task automatic run_one(input logic signed [data_width-1:0] x,
                         input logic signed [data_width-1:0] y,
                         input logic [angle_width-1:0] angle);
    apb_write(x_start_addr, 32'(x), 1'b0);
    apb_write(y_start_addr, 32'(y), 1'b0);
    launch(angle);
    wait_done();
    // done set, busy gone, one more completion
    read_check("status", status_addr, 32'h2);
    read_check("count", count_addr, expected_count);
    check_results(cordic_model(x, y, angle));
  endtask

  initial
  begin
    logic signed [data_width-1:0] rx;
    logic signed [data_width-1:0] ry;
    logic [angle_width-1:0] ra;
    logic signed [data_width-1:0] x_unit;
    logic [31:0] rd;
    clock = 1'b0;
    rst_n = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    expected_count = '0;
    lcg_state = 32'h02fb_d4ab;
    // 32767 / 1.6468, gain pre-compensated
    x_unit = 16'sd19897;

    repeat (3) @(posedge clock);
    @(negedge clock);
    rst_n = 1'b1;

    // everything reads zero out of reset
    read_check("status", status_addr, 32'h0);
    read_check("count", count_addr, 32'h0);
    read_check("cosine", cosine_addr, 32'h0);
    read_check("sine", sine_addr, 32'h0);
    read_check("x_start", x_start_addr, 32'h0);
    read_check("y_start", y_start_addr, 32'h0);
    read_check("angle", angle_addr, 32'h0);

    // operand readback, upper write bits dropped and sign re-extended
    apb_write(x_start_addr, 32'hABCD_8001, 1'b0);
    apb_write(y_start_addr, 32'h0000_7FFE, 1'b0);
    apb_write(angle_addr, 32'h1234_C000, 1'b0);
    read_check("x_start", x_start_addr, 32'hFFFF_8001);
    read_check("y_start", y_start_addr, 32'h0000_7FFE);
    read_check("angle", angle_addr, 32'hFFFF_C000);
    // bus errors
    apb_read(8'h20, 1'b1, rd);
    apb_write(8'h24, 32'h0, 1'b1);
    apb_write(status_addr, 32'h3, 1'b1);
    apb_write(cosine_addr, 32'h1, 1'b1);

    // fixed angles, all four quadrants
    run_one(x_unit, 16'sd0, 16'h0000);
    run_one(x_unit, 16'sd0, 16'h2000);
    run_one(x_unit, 16'sd0, 16'h4000);
    run_one(x_unit, 16'sd0, 16'h8000);
    run_one(x_unit, 16'sd0, 16'hC000);
    run_one(x_unit, 16'sd0, 16'hE000);

    // random operands, magnitudes kept inside the guard bit
    for (int n = 0; n < 200; n++)
    begin
      lcg_state = lcg_next(lcg_state);
      rx = $signed(lcg_state[31:16]) >>> 2;
      lcg_state = lcg_next(lcg_state);
      ry = $signed(lcg_state[31:16]) >>> 2;
      lcg_state = lcg_next(lcg_state);
      ra = lcg_state[31:16];
      run_one(rx, ry, ra);
    end

    // several rotations in flight, last one wins
    apb_write(x_start_addr, 32'(16'sd12000), 1'b0);
    apb_write(y_start_addr, 32'(-16'sd5000), 1'b0);
    launch(16'h1234);
    launch(16'h6000);
    launch(16'hA000);
    launch(16'hF100);
    wait_idle();
    read_check("count", count_addr, expected_count);
    read_check("status", status_addr, 32'h2);
    check_results(cordic_model(16'sd12000, -16'sd5000, 16'hF100));

    // start drops done while the rotation runs
    launch(16'h3000);
    read_check("status", status_addr, 32'h1);
    wait_done();
    read_check("status", status_addr, 32'h2);
    read_check("count", count_addr, expected_count);
    check_results(cordic_model(16'sd12000, -16'sd5000, 16'h3000));

    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
design/cordic_pkg.sv
design/cordic_rotator.sv
design/cordic_regs.sv
design/cordic_top.sv
dv/cordic_tb.sv

//--- Makefile
# Verilator flow for the CORDIC engine
# make lint checks the RTL, make sim builds and runs the testbench

OBJ_DIR = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --top-module cordic_top \
	  design/cordic_pkg.sv design/cordic_rotator.sv \
	  design/cordic_regs.sv design/cordic_top.sv

sim:
	verilator --binary --timing -f filelist.f --top-module cordic_tb \
	  -Mdir $(OBJ_DIR) -o cordic_tb_sim
	./$(OBJ_DIR)/cordic_tb_sim

clean:
	rm -rf $(OBJ_DIR)
